// ==== exec_core.f ====
logic/exec_pkg.sv
logic/exec_dispatch.sv
logic/branch_unit.sv
logic/alu_lane.sv
logic/writeback_arbiter.sv
logic/exec_core.sv
verif/exec_core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= exec_core_tb
FILELIST  ?= exec_core.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(BUILD_DIR)

// ==== verif/exec_core_tb.sv ====
`timescale 1ns/1ps

module exec_core_tb
    import exec_pkg::*;
();

    // single-cycle, multiply, branch, back-pressure and random stream orders
    localparam int MAX_INSTR = 10 * 8 + 8 + 8 * 8 + NUM_LANES + 2 + 60;
    localparam int CLK_NS = 10;
    localparam func3_t ALU_F3 [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
    localparam func7_t ALU_F7 [10] = '{7'd0, ALT_FUNC7, 7'd0, 7'd0, 7'd0, 7'd0, 7'd0, ALT_FUNC7,
                                       7'd0, 7'd0};

    logic       clk = 1'b0;
    logic       rst;
    logic       order;
    exec_info_t exec_info;
    logic       accepted;
    write_d_r_t write_d_r;
    j_b_info_t  j_b_info;
    logic       busy;

    // scoreboard indexed by pa_rd
    word_t expect_data [64];
    logic  expect_valid [64];
    int    pending = 0;
    int    errors = 0;
    int    writes = 0;
    preg_t next_rd = '0;

    exec_core dut (
        .clk       (clk),
        .rst       (rst),
        .order     (order),
        .exec_info (exec_info),
        .accepted  (accepted),
        .write_d_r (write_d_r),
        .j_b_info  (j_b_info),
        .busy      (busy)
    );

    always #5 clk = ~clk;

    task automatic report_mismatch(input string name, input word_t exp, input word_t act);
        $display("Fail at %0t: %s expected %h got %h", $time, name, exp, act);
        errors++;
    endtask

    function automatic word_t alu_expect(input exec_info_t info);
        word_t a;
        word_t b;
        logic [4:0] sh;
        a = info.rs1;
        b = info.rs2;
        sh = b[4:0];
        case (info.func3)
            3'd0: begin
                if (info.func7 == MUL_FUNC7)
                    return a * b;
                return (info.func7 == ALT_FUNC7) ? a - b : a + b;
            end
            3'd1: return a << sh;
            3'd2: return ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: begin
                // sign fill for the arithmetic shift
                if (info.func7 == ALT_FUNC7 && a[31])
                    return (a >> sh) | ~(32'hFFFF_FFFF >> sh);
                return a >> sh;
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input func3_t f3, input word_t a, input word_t b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
            3'd5: return (a ^ 32'h8000_0000) >= (b ^ 32'h8000_0000);
            3'd6: return a < b;
            3'd7: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // equal, less, greater, sign crossings, random, shift edges
    task automatic operand_pair(input int k, output word_t a, output word_t b);
        case (k)
            0: {a, b} = {32'd5, 32'd5};
            1: {a, b} = {32'd3, 32'd9};
            2: {a, b} = {32'd9, 32'd3};
            3: {a, b} = {32'h8000_0000, 32'd1};
            4: {a, b} = {32'd1, 32'hFFFF_FFFF};
            5: {a, b} = {$urandom, $urandom};
            6: {a, b} = {32'hFFFF_FFFF, 32'h0000_001F};
            default: {a, b} = {32'h7FFF_FFFF, 32'h8000_0000};
        endcase
    endtask

    function automatic exec_info_t build_info(input exec_type_e t, input func3_t f3,
                                              input func7_t f7, input word_t a, input word_t b);
        exec_info_t info;
        info.exec_type = t;
        info.func3 = f3;
        info.func7 = f7;
        info.pa_rd = next_rd;
        info.rs1 = a;
        info.rs2 = b;
        info.ctx = context_t'($urandom);
        return info;
    endfunction

    // starts on a falling edge and ends one falling edge after the transfer
    task automatic issue(input exec_info_t info, output int waits);
        j_b_info_t jb_exp;
        waits = 0;
        order = 1'b1;
        exec_info = info;
        #1;
        while (!accepted) begin
            @(negedge clk);
            #1;
            waits++;
        end
        if (info.exec_type == EXEC_BRANCH) begin
            jb_exp = '{branch: 1'b1, hazard: branch_taken(info.func3, info.rs1, info.rs2),
                       ctx: info.ctx};
            if (j_b_info !== jb_exp)
                report_mismatch("j_b_info", word_t'(jb_exp), word_t'(j_b_info));
        end else if (info.exec_type == EXEC_ALU) begin
            if (expect_valid[info.pa_rd]) begin
                $display("Error at %0t: pa_rd %0d issued again while pending", $time, info.pa_rd);
                errors++;
            end
            expect_data[info.pa_rd] = alu_expect(info);
            expect_valid[info.pa_rd] = 1'b1;
            pending++;
            next_rd = next_rd + 6'd1;
        end
        @(negedge clk);
        order = 1'b0;
        exec_info = '0;
    endtask

    task automatic drain();
        int guard;
        guard = 0;
        #1;
        while ((pending != 0 || busy) && guard < 400) begin
            @(negedge clk);
            #1;
            guard++;
        end
        if (pending != 0) begin
            $display("Error at %0t: %0d results never written back", $time, pending);
            errors++;
        end
        @(negedge clk);
    endtask

    always @(negedge clk) begin
        if (!rst && write_d_r.valid) begin
            writes++;
            if ($isunknown(write_d_r.pa_rd) || !expect_valid[write_d_r.pa_rd]) begin
                $display("Error at %0t: write_d_r to pa_rd %0d with nothing pending",
                         $time, write_d_r.pa_rd);
                errors++;
            end else begin
                if (write_d_r.data !== expect_data[write_d_r.pa_rd])
                    report_mismatch("write_d_r.data", expect_data[write_d_r.pa_rd],
                                    write_d_r.data);
                expect_valid[write_d_r.pa_rd] = 1'b0;
                pending--;
            end
        end
    end

    task automatic check_reset_state();
        #1;
        if (write_d_r.valid !== 1'b0)
            report_mismatch("write_d_r.valid", 32'd0, word_t'(write_d_r.valid));
        if (j_b_info.branch !== 1'b0)
            report_mismatch("j_b_info.branch", 32'd0, word_t'(j_b_info.branch));
        if (busy !== 1'b0)
            report_mismatch("busy", 32'd0, word_t'(busy));
        if (accepted !== 1'b0)
            report_mismatch("accepted", 32'd0, word_t'(accepted));
        @(negedge clk);
    endtask

    task automatic single_cycle_ops();
        word_t a;
        word_t b;
        preg_t rd;
        int waits;
        for (int op = 0; op < 10; op++) begin
            for (int k = 0; k < 8; k++) begin
                operand_pair(k, a, b);
                rd = next_rd;
                issue(build_info(EXEC_ALU, ALU_F3[op], ALU_F7[op], a, b), waits);
                // accept cycle plus two
                @(negedge clk);
                if (write_d_r.valid !== 1'b1)
                    report_mismatch("write_d_r.valid", 32'd1, word_t'(write_d_r.valid));
                if (write_d_r.pa_rd !== rd)
                    report_mismatch("write_d_r.pa_rd", word_t'(rd), word_t'(write_d_r.pa_rd));
                drain();
            end
        end
    endtask

    task automatic multiply_ops();
        word_t a;
        word_t b;
        int waits;
        for (int k = 0; k < 8; k++) begin
            operand_pair(k == 0 ? 5 : k, a, b);
            issue(build_info(EXEC_ALU, F3_ADD, MUL_FUNC7, a, b), waits);
            drain();
        end
    endtask

    task automatic branch_compares();
        word_t a;
        word_t b;
        int waits;
        for (int f3 = 0; f3 < 8; f3++) begin
            for (int k = 0; k < 8; k++) begin
                operand_pair(k, a, b);
                issue(build_info(EXEC_BRANCH, func3_t'(f3), 7'd0, a, b), waits);
            end
        end
    endtask

    task automatic lane_backpressure();
        int waits;
        for (int n = 0; n < NUM_LANES; n++) begin
            issue(build_info(EXEC_ALU, F3_ADD, MUL_FUNC7, $urandom, $urandom), waits);
            if (waits != 0) begin
                $display("Error at %0t: multiply order waited %0d cycles", $time, waits);
                errors++;
            end
        end
        if (busy !== 1'b1)
            report_mismatch("busy", 32'd1, word_t'(busy));
        issue(build_info(EXEC_BRANCH, F3_BNE, 7'd0, 32'd1, 32'd2), waits);
        if (waits != 0) begin
            $display("Error at %0t: branch order waited %0d cycles", $time, waits);
            errors++;
        end
        issue(build_info(EXEC_ALU, F3_XOR, 7'd0, $urandom, $urandom), waits);
        if (waits == 0) begin
            $display("Error at %0t: ALU order accepted while every lane was busy", $time);
            errors++;
        end
        drain();
    endtask

    task automatic mixed_stream();
        int pick;
        int op;
        int waits;
        for (int n = 0; n < 60; n++) begin
            pick = $urandom % 8;
            op = $urandom % 10;
            if (pick < 5)
                issue(build_info(EXEC_ALU, ALU_F3[op], ALU_F7[op], $urandom, $urandom), waits);
            else if (pick == 5)
                issue(build_info(EXEC_ALU, F3_ADD, MUL_FUNC7, $urandom, $urandom), waits);
            else if (pick == 6)
                issue(build_info(EXEC_BRANCH, func3_t'($urandom), 7'd0, $urandom, $urandom),
                      waits);
            else
                issue(build_info(EXEC_NONE, 3'd0, 7'd0, 32'd0, 32'd0), waits);
        end
        drain();
    endtask

    initial begin
        #(MAX_INSTR * 40 * CLK_NS + 2000);
        $display("Error: watchdog expired before the tests finished");
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        void'($urandom(73));
        for (int i = 0; i < 64; i++)
            expect_valid[i] = 1'b0;
        rst = 1'b1;
        order = 1'b0;
        exec_info = '0;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        check_reset_state();
        single_cycle_ops();
        multiply_ops();
        branch_compares();
        lane_backpressure();
        mixed_stream();
        $display("writes %0d, errors %0d", writes, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

// ==== logic/exec_core.sv ====
`timescale 1ns/1ps

module exec_core
    import exec_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       order,
    input  exec_info_t exec_info,
    output logic       accepted,
    output write_d_r_t write_d_r,
    output j_b_info_t  j_b_info,
    output logic       busy
);

    lane_mask_t lane_order;
    lane_mask_t lane_busy;
    lane_mask_t lane_grant;
    logic       branch_order;
    write_d_r_t lane_result [NUM_LANES];

    exec_dispatch m_dispatch (
        .order        (order),
        .exec_info    (exec_info),
        .lane_busy    (lane_busy),
        .accepted     (accepted),
        .lane_order   (lane_order),
        .branch_order (branch_order)
    );

    branch_unit m_branch (
        .branch_order (branch_order),
        .func3        (exec_info.func3),
        .rs1          (exec_info.rs1),
        .rs2          (exec_info.rs2),
        .ctx          (exec_info.ctx),
        .j_b_info     (j_b_info)
    );

    // all lanes see the same instruction, only one gets the order bit
    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        alu_lane m_lane (
            .clk        (clk),
            .rst        (rst),
            .lane_order (lane_order[i]),
            .exec_info  (exec_info),
            .grant      (lane_grant[i]),
            .busy       (lane_busy[i]),
            .result     (lane_result[i])
        );
    end

    writeback_arbiter m_arb (
        .clk         (clk),
        .rst         (rst),
        .lane_result (lane_result),
        .lane_grant  (lane_grant),
        .write_d_r   (write_d_r)
    );

    assign busy = (|lane_busy) | order;

endmodule

// ==== logic/writeback_arbiter.sv ====
`timescale 1ns/1ps

module writeback_arbiter
    import exec_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  write_d_r_t lane_result [NUM_LANES],
    output lane_mask_t lane_grant,
    output write_d_r_t write_d_r
);

    lane_idx_t last_q;
    lane_idx_t cand;
    lane_idx_t pick;
    logic      found;

    logic  wr_valid;
    preg_t wr_rd;
    word_t wr_data;

    // search starts one past the previous winner
    always_comb begin
        found      = 1'b0;
        pick       = last_q;
        cand       = last_q;
        lane_grant = '0;
        for (int k = 1; k <= NUM_LANES; k++) begin
            cand = lane_idx_t'(last_q + k);
            if (!found && lane_result[cand].valid) begin
                found = 1'b1;
                pick  = cand;
            end
        end
        if (found)
            lane_grant[pick] = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_valid <= 1'b0;
            last_q   <= '0;
        end else begin
            wr_valid <= found;
            if (found)
                last_q <= pick;
        end
    end

    always_ff @(posedge clk) begin
        if (found) begin
            wr_rd   <= lane_result[pick].pa_rd;
            wr_data <= lane_result[pick].data;
        end
    end

    assign write_d_r.valid = wr_valid;
    assign write_d_r.pa_rd = wr_rd;
    assign write_d_r.data  = wr_data;

    assert property (@(posedge clk) disable iff (rst) $onehot0(lane_grant))
    else $error("writeback_arbiter: grant not one-hot");

endmodule

// ==== logic/alu_lane.sv ====
`timescale 1ns/1ps

module alu_lane
    import exec_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       lane_order,
    input  exec_info_t exec_info,
    input  logic       grant,
    output logic       busy,
    output write_d_r_t result
);

    lane_state_e state;
    logic [4:0]  step_cnt;
    word_t       mcand;
    word_t       mplier;
    word_t       data_q;
    preg_t       rd_q;

    logic  is_mul;
    logic  is_alt;
    logic  [4:0] shamt;
    word_t alu_out;

    assign is_mul = (exec_info.func7 == MUL_FUNC7) && (exec_info.func3 == F3_ADD);
    assign is_alt = (exec_info.func7 == ALT_FUNC7);
    assign shamt  = exec_info.rs2[4:0];

    always_comb begin
        case (exec_info.func3)
            F3_ADD:  alu_out = is_alt ? exec_info.rs1 - exec_info.rs2
                                      : exec_info.rs1 + exec_info.rs2;
            F3_SLL:  alu_out = exec_info.rs1 << shamt;
            F3_SLT:  alu_out = {31'b0, $signed(exec_info.rs1) < $signed(exec_info.rs2)};
            F3_SLTU: alu_out = {31'b0, exec_info.rs1 < exec_info.rs2};
            F3_XOR:  alu_out = exec_info.rs1 ^ exec_info.rs2;
            F3_SRL: begin
                // sra on the alt func7
                if (is_alt)
                    alu_out = $signed(exec_info.rs1) >>> shamt;
                else
                    alu_out = exec_info.rs1 >> shamt;
            end
            F3_OR:   alu_out = exec_info.rs1 | exec_info.rs2;
            default: alu_out = exec_info.rs1 & exec_info.rs2;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= LANE_IDLE;
            step_cnt <= '0;
        end else begin
            case (state)
                LANE_IDLE: begin
                    if (lane_order) begin
                        state    <= is_mul ? LANE_MUL : LANE_HOLD;
                        step_cnt <= '0;
                    end
                end
                LANE_MUL: begin
                    step_cnt <= step_cnt + 5'd1;
                    if (step_cnt == 5'd31)
                        state <= LANE_HOLD;
                end
                default: begin
                    if (grant)
                        state <= LANE_IDLE;
                end
            endcase
        end
    end

    // data_q doubles as the product accumulator
    always_ff @(posedge clk) begin
        if (state == LANE_IDLE && lane_order) begin
            rd_q   <= exec_info.pa_rd;
            mcand  <= exec_info.rs1;
            mplier <= exec_info.rs2;
            data_q <= is_mul ? '0 : alu_out;
        end else if (state == LANE_MUL) begin
            if (mplier[0])
                data_q <= data_q + mcand;
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    assign busy         = (state != LANE_IDLE);
    assign result.valid = (state == LANE_HOLD);
    assign result.pa_rd = rd_q;
    assign result.data  = data_q;

    assert property (@(posedge clk) disable iff (rst) grant |-> state == LANE_HOLD)
    else $error("alu_lane: grant outside hold");

endmodule

// ==== logic/branch_unit.sv ====
`timescale 1ns/1ps

module branch_unit
    import exec_pkg::*;
(
    input  logic      branch_order,
    input  func3_t    func3,
    input  word_t     rs1,
    input  word_t     rs2,
    input  context_t  ctx,
    output j_b_info_t j_b_info
);

    logic taken;

    always_comb begin
        case (func3)
            F3_BEQ:  taken = (rs1 == rs2);
            F3_BNE:  taken = (rs1 != rs2);
            F3_BLT:  taken = ($signed(rs1) < $signed(rs2));
            F3_BGE:  taken = ($signed(rs1) >= $signed(rs2));
            F3_BLTU: taken = (rs1 < rs2);
            F3_BGEU: taken = (rs1 >= rs2);
            // reserved codes fall through as not taken
            default: taken = 1'b0;
        endcase
    end

    // hazard only when a real branch resolves taken
    assign j_b_info.branch = branch_order;
    assign j_b_info.hazard = branch_order & taken;
    assign j_b_info.ctx    = ctx;

endmodule

// ==== logic/exec_dispatch.sv ====
`timescale 1ns/1ps

module exec_dispatch
    import exec_pkg::*;
(
    input  logic       order,
    input  exec_info_t exec_info,
    input  lane_mask_t lane_busy,
    output logic       accepted,
    output lane_mask_t lane_order,
    output logic       branch_order
);

    // lowest clear bit of the busy mask
    lane_mask_t free_pick;

    assign free_pick = ~lane_busy & (lane_busy + lane_mask_t'(1));

    always_comb begin
        lane_order   = '0;
        branch_order = 1'b0;
        accepted     = 1'b0;
        if (order) begin
            case (exec_info.exec_type)
                EXEC_ALU: begin
                    lane_order = free_pick;
                    accepted   = |free_pick;
                end
                EXEC_BRANCH: begin
                    // comparator answers at once, never stalls
                    branch_order = 1'b1;
                    accepted     = 1'b1;
                end
                default: begin
                    // nothing to execute, just retire it
                    accepted = 1'b1;
                end
            endcase
        end
    end

    always_comb begin
        assert final ($onehot0(lane_order))
        else $error("dispatch: more than one lane ordered");
    end

    always_comb begin
        assert final (!accepted || order)
        else $error("dispatch: accepted without order");
    end

endmodule

// ==== logic/exec_pkg.sv ====
package exec_pkg;

    localparam int NUM_LANES = 4;

    typedef logic [31:0] word_t;
    typedef logic [5:0]  preg_t;
    typedef logic [3:0]  context_t;
    typedef logic [2:0]  func3_t;
    typedef logic [6:0]  func7_t;

    typedef logic [1:0]           lane_idx_t;
    typedef logic [NUM_LANES-1:0] lane_mask_t;

    typedef enum logic [1:0] {
        EXEC_ALU    = 2'd0,
        EXEC_BRANCH = 2'd1,
        EXEC_NONE   = 2'd2
    } exec_type_e;

    typedef enum logic [1:0] {
        LANE_IDLE = 2'd0,
        LANE_MUL  = 2'd1,
        LANE_HOLD = 2'd2
    } lane_state_e;

    // func7 selectors
    localparam func7_t MUL_FUNC7 = 7'b0000001;
    localparam func7_t ALT_FUNC7 = 7'b0100000;

    // register-register alu codes
    localparam func3_t F3_ADD  = 3'd0;
    localparam func3_t F3_SLL  = 3'd1;
    localparam func3_t F3_SLT  = 3'd2;
    localparam func3_t F3_SLTU = 3'd3;
    localparam func3_t F3_XOR  = 3'd4;
    localparam func3_t F3_SRL  = 3'd5;
    localparam func3_t F3_OR   = 3'd6;
    localparam func3_t F3_AND  = 3'd7;

    // branch codes
    localparam func3_t F3_BEQ  = 3'd0;
    localparam func3_t F3_BNE  = 3'd1;
    localparam func3_t F3_BLT  = 3'd4;
    localparam func3_t F3_BGE  = 3'd5;
    localparam func3_t F3_BLTU = 3'd6;
    localparam func3_t F3_BGEU = 3'd7;

    typedef struct packed {
        exec_type_e exec_type;
        func3_t     func3;
        func7_t     func7;
        preg_t      pa_rd;
        word_t      rs1;
        word_t      rs2;
        context_t   ctx;
    } exec_info_t;

    typedef struct packed {
        logic  valid;
        preg_t pa_rd;
        word_t data;
    } write_d_r_t;

    typedef struct packed {
        logic     branch;
        logic     hazard;
        context_t ctx;
    } j_b_info_t;

endpackage
